// ==== flist.f ====
+incdir+include
src/gfx_pkg.sv
src/gfx_vram_bank.sv
src/gfx_memory_arbiter.sv
src/gfx_fetch_unit.sv
src/gfx_fetch_ctrl.sv
src/gfx_vram_fetch_top.sv
dv/gfx_vram_fetch_tb.sv

// ==== dv/gfx_vram_fetch_tb.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"

module gfx_vram_fetch_tb;

	typedef struct packed {
		logic                                              frame;
		logic                                              poke;   // extra line_start while busy
		logic [7:0]                                        lines;
		gfx_pkg::gfx_layer_cfg_t [`GFX_NUM_LAYERS-1:0]     cfg;
	} test_row_t;

	localparam int NUM_ROWS     = 11;
	localparam int LINE_TIMEOUT = 1000;

	logic                    clk;
	logic                    rst;
	gfx_pkg::gfx_host_wr_t   host_wr;
	logic                    frame_start;
	logic                    line_start;
	gfx_pkg::gfx_layer_cfg_t layer_cfg [`GFX_NUM_LAYERS];
	logic                    busy;
	logic                    line_done;
	gfx_pkg::gfx_word_t      words     [`GFX_NUM_LAYERS];

	logic [`GFX_DATA_W-1:0]  model     [0:(1 << `GFX_ADDR_W)-1];
	bit                      loaded    [0:(1 << `GFX_ADDR_W)-1];
	logic [`GFX_DATA_W-1:0]  exp_data  [`GFX_NUM_LAYERS][256];
	logic [`GFX_NUM_LAYERS-1:0][`GFX_CNT_W-1:0] rx_cnt;
	logic [`GFX_NUM_LAYERS-1:0][`GFX_CNT_W-1:0] exp_cnt;
	test_row_t               rows      [NUM_ROWS];
	logic [`GFX_ADDR_W-1:0]  exp_line;
	logic [31:0]             seed;
	int                      done_cnt;
	int                      err_value;
	int                      err_other;

	gfx_vram_fetch_top gfx_vram_fetch_top_i (
		.clk         (clk),
		.rst         (rst),
		.host_wr     (host_wr),
		.frame_start (frame_start),
		.line_start  (line_start),
		.layer_cfg   (layer_cfg),
		.busy        (busy),
		.line_done   (line_done),
		.words       (words)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic gfx_pkg::gfx_layer_cfg_t lcfg(input logic en, input logic [15:0] base,
			input logic [15:0] stride, input logic [7:0] count);
		gfx_pkg::gfx_layer_cfg_t c;
		c.en     = en;
		c.base   = base;
		c.stride = stride;
		c.count  = count;
		return c;
	endfunction

	// word k of a layer on a given line, 16 bit wrap
	function automatic logic [`GFX_ADDR_W-1:0] addr_of(input gfx_pkg::gfx_layer_cfg_t c,
			input logic [`GFX_ADDR_W-1:0] line, input int k);
		logic [`GFX_ADDR_W-1:0] a;
		a = c.base + line * c.stride;
		a = a + `GFX_ADDR_W'(k);
		return a;
	endfunction

	function automatic logic active(input gfx_pkg::gfx_layer_cfg_t c);
		return c.en && (c.count != '0);
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h exp %h", name, got, exp);
			err_value++;
		end
	endtask

	task automatic check_word(input gfx_pkg::gfx_word_t got, input gfx_pkg::gfx_word_t exp,
			input int layer);
		if (got.index !== exp.index) begin
			$display("[FAIL] words[%0d].index got %h exp %h", layer, got.index, exp.index);
			err_value++;
		end
		if (got.data !== exp.data) begin
			$display("[FAIL] words[%0d].data got %h exp %h", layer, got.data, exp.data);
			err_value++;
		end
	endtask

	task automatic check_line(input int done_seen,
			input logic [`GFX_NUM_LAYERS-1:0][`GFX_CNT_W-1:0] rx,
			input logic [`GFX_NUM_LAYERS-1:0][`GFX_CNT_W-1:0] exp);
		if (done_seen != 1) begin
			$display("[FAIL] line_done pulses got %h exp %h", done_seen, 1);
			err_value++;
		end
		for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
			if (rx[i] !== exp[i]) begin
				$display("[FAIL] words[%0d] count got %h exp %h", i, rx[i], exp[i]);
				err_value++;
			end
		end
	endtask

	// compares each word as it arrives, counts line_done pulses
	always @(negedge clk) begin : word_monitor
		gfx_pkg::gfx_word_t exp_w;
		if (!rst) begin
			if (line_done) begin
				done_cnt++;
			end
			for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
				if (words[i].valid) begin
					if (rx_cnt[i] < exp_cnt[i]) begin
						exp_w.valid = 1'b1;
						exp_w.index = rx_cnt[i];
						exp_w.data  = exp_data[i][rx_cnt[i]];
						check_word(words[i], exp_w, i);
					end else begin
						$display("layer %0d delivered a word it was not asked for", i);
						err_other++;
					end
					rx_cnt[i] = rx_cnt[i] + 1'b1;
				end
			end
		end
	end

	task automatic build_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			rows[r]       = '0;
			rows[r].frame = 1'b1;
			rows[r].lines = 8'd1;
		end
		rows[0].cfg[0] = lcfg(1'b1, 16'h0100, 16'h0020, 8'd8);  // each layer alone
		rows[1].cfg[1] = lcfg(1'b1, 16'h1200, 16'h0020, 8'd5);
		rows[2].cfg[2] = lcfg(1'b1, 16'h2300, 16'h0020, 8'd6);
		rows[3].cfg[3] = lcfg(1'b1, 16'h3400, 16'h0020, 8'd7);
		rows[4].lines  = 8'd2;  // all in bank 0
		rows[4].cfg[0] = lcfg(1'b1, 16'h0400, 16'h0010, 8'd6);
		rows[4].cfg[1] = lcfg(1'b1, 16'h0480, 16'h0010, 8'd5);
		rows[4].cfg[2] = lcfg(1'b1, 16'h0500, 16'h0010, 8'd4);
		rows[4].cfg[3] = lcfg(1'b1, 16'h0580, 16'h0010, 8'd3);
		rows[5].cfg[0] = lcfg(1'b1, 16'h0800, 16'h0000, 8'd6);
		rows[5].cfg[1] = lcfg(1'b1, 16'h8800, 16'h0000, 8'd6);
		rows[5].cfg[2] = lcfg(1'b1, 16'hc800, 16'h0000, 8'd6);
		rows[5].cfg[3] = lcfg(1'b1, 16'h3ffc, 16'h0000, 8'd8);  // crosses 4000h
		rows[6].lines  = 8'd3;
		rows[6].cfg[0] = lcfg(1'b1, 16'h0a00, 16'h0040, 8'd4);
		rows[6].cfg[1] = lcfg(1'b1, 16'hc000, 16'h8000, 8'd3);  // wraps every other line
		rows[6].cfg[2] = lcfg(1'b0, 16'h2000, 16'h0000, 8'd5);
		rows[6].cfg[3] = lcfg(1'b1, 16'h0010, 16'hfff0, 8'd2);
		rows[7]        = rows[6];
		rows[7].frame  = 1'b0;  // lines 3 and 4
		rows[7].lines  = 8'd2;
		rows[8].frame  = 1'b0;
		rows[8].lines  = 8'd2;
		rows[8].cfg[1] = lcfg(1'b1, 16'h1000, 16'h0000, 8'd0);  // count 0, no words
		rows[9].poke   = 1'b1;
		rows[9].cfg[0] = lcfg(1'b1, 16'h0c00, 16'h0000, 8'd10);
		rows[9].cfg[1] = lcfg(1'b1, 16'h0c40, 16'h0000, 8'd6);
		rows[10].frame  = 1'b0;  // ignored start must not count a line
		rows[10].cfg[0] = lcfg(1'b1, 16'h0d00, 16'h0001, 8'd3);
	endtask

	task automatic write_word(input logic [`GFX_ADDR_W-1:0] a, input logic [`GFX_DATA_W-1:0] d);
		host_wr.en   = 1'b1;
		host_wr.addr = a;
		host_wr.data = d;
		model[a]     = d;
		step();
	endtask

	// loads every word that the table reads
	task automatic preload();
		logic [`GFX_ADDR_W-1:0] line;
		logic [`GFX_ADDR_W-1:0] a;
		line = '0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (rows[r].frame) begin
				line = '0;
			end
			for (int n = 0; n < rows[r].lines; n++) begin
				for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
					for (int k = 0; active(rows[r].cfg[i]) && k < rows[r].cfg[i].count; k++) begin
						a = addr_of(rows[r].cfg[i], line, k);
						if (!loaded[a]) begin
							seed      = xorshift(seed);
							loaded[a] = 1'b1;
							write_word(a, seed[`GFX_DATA_W-1:0]);
						end
					end
				end
				line = line + 1'b1;
			end
		end
		host_wr = '0;
		step();
	endtask

	task automatic run_line(input int r, input logic poke);
		int t;
		for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
			rx_cnt[i]  = '0;
			exp_cnt[i] = '0;
			if (active(rows[r].cfg[i])) begin
				exp_cnt[i] = rows[r].cfg[i].count;
				for (int k = 0; k < rows[r].cfg[i].count; k++) begin
					exp_data[i][k] = model[addr_of(rows[r].cfg[i], exp_line, k)];
				end
			end
		end
		done_cnt   = 0;
		line_start = 1'b1;
		step();
		line_start = 1'b0;
		if (poke) begin
			t = 0;
			while (!busy && t < 50) begin
				step();
				t++;
			end
			if (!busy) begin
				$display("timeout waiting for busy in row %0d", r);
				err_other++;
			end else begin
				line_start = 1'b1;
				step();
				line_start = 1'b0;
			end
		end
		t = 0;
		while (done_cnt == 0 && t < LINE_TIMEOUT) begin
			step();
			t++;
		end
		if (done_cnt == 0) begin
			$display("timeout: line %0d of row %0d never finished", exp_line, r);
			err_other++;
		end
		repeat (12) step();  // catch stray words or pulses
		check_line(done_cnt, rx_cnt, exp_cnt);
		check_level("busy", busy, 1'b0);
	endtask

	initial begin
		rst         = 1'b1;
		host_wr     = '0;
		frame_start = 1'b0;
		line_start  = 1'b0;
		for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
			layer_cfg[i] = '0;
		end
		rx_cnt    = '0;
		exp_cnt   = '0;
		done_cnt  = 0;
		err_value = 0;
		err_other = 0;
		exp_line  = '0;
		seed      = 32'h0ab6_56fa;
		build_table();
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int n = 0; n < 20; n++) begin
			step();
			check_level("busy", busy, 1'b0);
			check_level("line_done", line_done, 1'b0);
			for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
				check_level($sformatf("words[%0d].valid", i), words[i].valid, 1'b0);
			end
		end

		preload();
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
				layer_cfg[i] = rows[r].cfg[i];
			end
			if (rows[r].frame) begin
				frame_start = 1'b1;
				step();
				frame_start = 1'b0;
				exp_line    = '0;
			end
			for (int n = 0; n < rows[r].lines; n++) begin
				run_line(r, rows[r].poke && n == 0);
				exp_line = exp_line + 1'b1;
			end
		end

		$display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
		if (err_value + err_other == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== src/gfx_vram_fetch_top.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"

module gfx_vram_fetch_top (
	input  logic                    clk,
	input  logic                    rst,
	input  gfx_pkg::gfx_host_wr_t   host_wr,
	input  logic                    frame_start,
	input  logic                    line_start,
	input  gfx_pkg::gfx_layer_cfg_t layer_cfg [`GFX_NUM_LAYERS],
	output logic                    busy,
	output logic                    line_done,
	output gfx_pkg::gfx_word_t      words     [`GFX_NUM_LAYERS]
);

	gfx_pkg::gfx_fetch_cmd_t cmd      [`GFX_NUM_LAYERS];
	logic                    done     [`GFX_NUM_LAYERS];
	gfx_pkg::gfx_mem_req_t   req      [`GFX_NUM_LAYERS];
	gfx_pkg::gfx_mem_rsp_t   rsp      [`GFX_NUM_LAYERS];
	gfx_pkg::gfx_bank_req_t  bank_req [`GFX_NUM_BANKS];
	gfx_pkg::gfx_bank_rsp_t  bank_rsp [`GFX_NUM_BANKS];

	gfx_fetch_ctrl gfx_fetch_ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.line_start  (line_start),
		.layer_cfg   (layer_cfg),
		.cmd         (cmd),
		.done        (done),
		.busy        (busy),
		.line_done   (line_done)
	);

	// one fetcher per layer, sprite at index 0
	for (genvar i = 0; i < `GFX_NUM_LAYERS; i++) begin : g_layer
		gfx_fetch_unit gfx_fetch_unit_i (
			.clk  (clk),
			.rst  (rst),
			.cmd  (cmd[i]),
			.req  (req[i]),
			.rsp  (rsp[i]),
			.word (words[i]),
			.done (done[i])
		);
	end

	gfx_memory_arbiter gfx_memory_arbiter_i (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.rsp      (rsp),
		.bank_req (bank_req),
		.bank_rsp (bank_rsp)
	);

	// each bank picks its own host writes
	for (genvar b = 0; b < `GFX_NUM_BANKS; b++) begin : g_bank
		gfx_vram_bank gfx_vram_bank_i (
			.clk      (clk),
			.rst      (rst),
			.bank_sel ((`GFX_ADDR_W-`GFX_BANK_ADDR_W)'(b)),
			.host_wr  (host_wr),
			.req      (bank_req[b]),
			.rsp      (bank_rsp[b])
		);
	end

endmodule

// ==== src/gfx_fetch_ctrl.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"

module gfx_fetch_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    frame_start,
	input  logic                    line_start,
	input  gfx_pkg::gfx_layer_cfg_t layer_cfg [`GFX_NUM_LAYERS],
	output gfx_pkg::gfx_fetch_cmd_t cmd       [`GFX_NUM_LAYERS],
	input  logic                    done      [`GFX_NUM_LAYERS],
	output logic                    busy,
	output logic                    line_done
);

	logic [`GFX_ADDR_W-1:0]    line_cnt;
	logic [`GFX_ADDR_W-1:0]    line_use;
	logic [`GFX_NUM_LAYERS-1:0] en_mask;
	logic [`GFX_NUM_LAYERS-1:0] done_vec;
	logic [`GFX_NUM_LAYERS-1:0] pending;
	logic [`GFX_NUM_LAYERS-1:0] pending_nxt;
	logic                       accept;
	logic                       empty_line;
	logic                       finish;
	logic                       end_now;

	always_comb begin
		for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
			en_mask[i]  = layer_cfg[i].en && (layer_cfg[i].count != '0);  // count 0 is off
			done_vec[i] = done[i];
		end
	end

	assign line_use    = frame_start ? '0 : line_cnt;
	assign accept      = line_start && !busy;  // ignored while busy
	assign empty_line  = accept && (en_mask == '0);
	assign pending_nxt = pending & ~done_vec;
	assign finish      = busy && (pending_nxt == '0);
	assign end_now     = finish || empty_line;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			line_done <= 1'b0;
			pending   <= '0;
			line_cnt  <= '0;
			for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
				cmd[i].start <= 1'b0;
			end
		end else begin
			line_done <= end_now;
			line_cnt  <= line_use + {{(`GFX_ADDR_W-1){1'b0}}, end_now};
			for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
				cmd[i].start <= accept && en_mask[i];
			end
			if (accept && !empty_line) begin
				busy    <= 1'b1;
				pending <= en_mask;
			end else if (busy) begin
				pending <= pending_nxt;
				busy    <= !finish;
			end
		end

		if (accept) begin
			for (int i = 0; i < `GFX_NUM_LAYERS; i++) begin
				cmd[i].addr  <= layer_cfg[i].base + line_use * layer_cfg[i].stride;
				cmd[i].count <= layer_cfg[i].count;
			end
		end
	end

	// done only from a layer started this line
	for (genvar i = 0; i < `GFX_NUM_LAYERS; i++) begin : g_done_chk
		a_done_pending: assert property (
			@(posedge clk) disable iff (rst)
			done[i] |-> pending[i]
		) else $error("done from layer %0d that was not started", i);
	end

endmodule

// ==== src/gfx_fetch_unit.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"

module gfx_fetch_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  gfx_pkg::gfx_fetch_cmd_t cmd,
	output gfx_pkg::gfx_mem_req_t  req,
	input  gfx_pkg::gfx_mem_rsp_t  rsp,
	output gfx_pkg::gfx_word_t     word,
	output logic                   done
);

	typedef enum logic [1:0] {
		s_idle,
		s_req,
		s_gap   // valid low one cycle after each ready
	} state_t;

	state_t                 state;
	logic [`GFX_ADDR_W-1:0] addr;
	logic [`GFX_CNT_W-1:0]  count;
	logic [`GFX_CNT_W-1:0]  idx;
	logic                   last;

	assign req.valid = (state == s_req);
	assign req.addr  = addr;
	assign last      = (idx == count - 1'b1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= s_idle;
			word.valid <= 1'b0;
			done       <= 1'b0;
		end else begin
			word.valid <= 1'b0;
			done       <= 1'b0;
			case (state)
				s_idle: begin
					if (cmd.start) begin
						state <= s_req;
					end
				end
				s_req: begin
					if (rsp.ready) begin
						word.valid <= 1'b1;
						done       <= last;  // with the last word
						state      <= last ? s_idle : s_gap;
					end
				end
				s_gap: state <= s_req;
				default: state <= s_idle;
			endcase
		end

		if (state == s_idle && cmd.start) begin
			addr  <= cmd.addr;
			count <= cmd.count;
			idx   <= '0;
		end
		if (state == s_req && rsp.ready) begin
			word.index <= idx;
			word.data  <= rsp.data;
			idx        <= idx + 1'b1;
			addr       <= addr + 1'b1;  // wraps at 64K
		end
	end

	a_start_idle: assert property (
		@(posedge clk) disable iff (rst)
		cmd.start |-> (state == s_idle)
	) else $error("fetch start while busy");

endmodule

// ==== src/gfx_memory_arbiter.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"

module gfx_memory_arbiter (
	input  logic                   clk,
	input  logic                   rst,
	input  gfx_pkg::gfx_mem_req_t  req      [`GFX_NUM_LAYERS],
	output gfx_pkg::gfx_mem_rsp_t  rsp      [`GFX_NUM_LAYERS],
	output gfx_pkg::gfx_bank_req_t bank_req [`GFX_NUM_BANKS],
	input  gfx_pkg::gfx_bank_rsp_t bank_rsp [`GFX_NUM_BANKS]
);

	logic [`GFX_NUM_BANKS-1:0][`GFX_NUM_LAYERS-1:0] hit;
	logic [`GFX_NUM_BANKS-1:0][`GFX_NUM_LAYERS-1:0] gnt;
	logic [`GFX_NUM_BANKS-1:0][`GFX_NUM_LAYERS-1:0] owner;  // layer held by each lock
	logic [`GFX_NUM_BANKS-1:0]                      locked;

	// bank decode and fixed priority with sprite first
	always_comb begin
		logic found;
		for (int b = 0; b < `GFX_NUM_BANKS; b++) begin
			found = 1'b0;
			gnt[b] = '0;
			for (int l = 0; l < `GFX_NUM_LAYERS; l++) begin
				hit[b][l] = req[l].valid &&
					(int'(req[l].addr[`GFX_ADDR_W-1:`GFX_BANK_ADDR_W]) == b);
			end
			if (locked[b]) begin
				gnt[b] = owner[b] & hit[b];  // only the locked layer
			end else begin
				for (int l = 0; l < `GFX_NUM_LAYERS; l++) begin
					if (hit[b][l] && !found) begin
						gnt[b][l] = 1'b1;
						found = 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		for (int b = 0; b < `GFX_NUM_BANKS; b++) begin
			bank_req[b] = '0;
			for (int l = 0; l < `GFX_NUM_LAYERS; l++) begin
				if (gnt[b][l]) begin
					bank_req[b].addr  = req[l].addr[`GFX_BANK_ADDR_W-1:0];
					bank_req[b].valid = 1'b1;
				end
			end
		end
	end

	// ungranted layers see ready low and data zero
	always_comb begin
		for (int l = 0; l < `GFX_NUM_LAYERS; l++) begin
			rsp[l] = '0;
			for (int b = 0; b < `GFX_NUM_BANKS; b++) begin
				if (gnt[b][l]) begin
					rsp[l].data  = bank_rsp[b].data;
					rsp[l].ready = bank_rsp[b].ready;
				end
			end
		end
	end

	// lock from the grant cycle through the ready cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			locked <= '0;
		end else begin
			for (int b = 0; b < `GFX_NUM_BANKS; b++) begin
				locked[b] <= (|gnt[b]) && !bank_rsp[b].ready;
			end
		end
		owner <= gnt;
	end

	for (genvar b = 0; b < `GFX_NUM_BANKS; b++) begin : g_bank_chk
		a_lock_stable: assert property (
			@(posedge clk) disable iff (rst)
			((|gnt[b]) && !bank_rsp[b].ready) |=> (gnt[b] == $past(gnt[b]))
		) else $error("bank %0d grant moved before ready", b);
	end

endmodule

// ==== src/gfx_vram_bank.sv ====
`timescale 1ns/10ps
`include "gfx_defs.svh"

module gfx_vram_bank (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic [`GFX_ADDR_W-`GFX_BANK_ADDR_W-1:0]     bank_sel,  // this bank's number
	input  gfx_pkg::gfx_host_wr_t                       host_wr,
	input  gfx_pkg::gfx_bank_req_t                      req,
	output gfx_pkg::gfx_bank_rsp_t                      rsp
);

	logic [`GFX_DATA_W-1:0] mem [0:(1 << `GFX_BANK_ADDR_W)-1];
	logic                   wr_hit;
	logic                   rd_take;

	assign wr_hit = host_wr.en &&
		(host_wr.addr[`GFX_ADDR_W-1:`GFX_BANK_ADDR_W] == bank_sel);

	// a new read is only taken while ready is low
	assign rd_take = req.valid && !rsp.ready;

	always_ff @(posedge clk) begin
		if (wr_hit) begin
			mem[host_wr.addr[`GFX_BANK_ADDR_W-1:0]] <= host_wr.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp.ready <= 1'b0;
		end else begin
			rsp.ready <= rd_take;  // one cycle ready
		end
		if (rd_take) begin
			rsp.data <= mem[req.addr];
		end
	end

	// host loads the memory only between lines
	a_no_wr_during_read: assert property (
		@(posedge clk) disable iff (rst)
		wr_hit |-> !req.valid
	) else $error("host write to bank %0d during a read", bank_sel);

endmodule

// ==== src/gfx_pkg.sv ====
`include "gfx_defs.svh"

package gfx_pkg;

	// layer read request toward the arbiter
	typedef struct packed {
		logic [`GFX_ADDR_W-1:0] addr;
		logic                   valid;
	} gfx_mem_req_t;

	typedef struct packed {
		logic [`GFX_DATA_W-1:0] data;
		logic                   ready;  // one cycle, data valid
	} gfx_mem_rsp_t;

	typedef struct packed {
		logic [`GFX_BANK_ADDR_W-1:0] addr;
		logic                        valid;
	} gfx_bank_req_t;

	typedef struct packed {
		logic [`GFX_DATA_W-1:0] data;
		logic                   ready;
	} gfx_bank_rsp_t;

	typedef struct packed {
		logic                   en;
		logic [`GFX_ADDR_W-1:0] addr;
		logic [`GFX_DATA_W-1:0] data;
	} gfx_host_wr_t;

	typedef struct packed {
		logic                   en;
		logic [`GFX_ADDR_W-1:0] base;
		logic [`GFX_ADDR_W-1:0] stride;  // words per line
		logic [`GFX_CNT_W-1:0]  count;
	} gfx_layer_cfg_t;

	typedef struct packed {
		logic                   start;
		logic [`GFX_ADDR_W-1:0] addr;
		logic [`GFX_CNT_W-1:0]  count;
	} gfx_fetch_cmd_t;

	typedef struct packed {
		logic                   valid;
		logic [`GFX_CNT_W-1:0]  index;
		logic [`GFX_DATA_W-1:0] data;
	} gfx_word_t;

endpackage

// ==== include/gfx_defs.svh ====
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// full video memory word address
`define GFX_ADDR_W       16
`define GFX_BANK_ADDR_W  14  // address inside one bank
`define GFX_DATA_W       16
`define GFX_NUM_BANKS    4

// 0 sprite, 1 bg0, 2 bg1, 3 overlay
`define GFX_NUM_LAYERS   4
`define GFX_CNT_W        8   // word count and word index

`endif
